/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_toom4_mul
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_ARGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/clmul_ks.sv */
`timescale 1ns/1ps

module clmul_ks (
    input  toom_pkg::op_t   a,
    input  toom_pkg::op_t   b,
    output toom_pkg::prod_t p
);
    import toom_pkg::*;

    // schoolbook carry-less product of two half-width polynomials
    function automatic logic [2*half_width-2:0] clmul_half(
        input logic [half_width-1:0] x,
        input logic [half_width-1:0] y
    );
        logic [2*half_width-2:0] acc;
        acc = '0;
        for (int i = 0; i < half_width; i++) begin
            if (y[i]) begin
                acc = acc ^ ({{(half_width - 1){1'b0}}, x} << i);
            end
        end
        return acc;
    endfunction

    logic [half_width-1:0] a_lo;
    logic [half_width-1:0] a_hi;
    logic [half_width-1:0] b_lo;
    logic [half_width-1:0] b_hi;

    logic [2*half_width-2:0] z_lo;
    logic [2*half_width-2:0] z_hi;
    logic [2*half_width-2:0] z_mid;
    logic [2*half_width-2:0] middle;

    assign a_lo = a[half_width-1:0];
    assign b_lo = b[half_width-1:0];

    // upper halves are one bit narrower
    assign a_hi = {{(2 * half_width - op_width){1'b0}}, a[op_width-1:half_width]};
    assign b_hi = {{(2 * half_width - op_width){1'b0}}, b[op_width-1:half_width]};

    assign z_lo = clmul_half(a_lo, b_lo);
    assign z_hi = clmul_half(a_hi, b_hi);
    assign z_mid = clmul_half(a_lo ^ a_hi, b_lo ^ b_hi);

    // karatsuba middle term, no carries in GF(2)
    assign middle = z_mid ^ z_lo ^ z_hi;

    // top bits of the shifted high product are always zero
    assign p = prod_t'(z_lo)
             ^ (prod_t'(middle) << half_width)
             ^ (prod_t'(z_hi) << (2 * half_width));

endmodule

/* rtl/exact_divider.sv */
`timescale 1ns/1ps

module exact_divider #(
    parameter logic [toom_pkg::divisor_degree:0] divisor = 5'b10011
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  toom_pkg::prod_t dividend,
    output toom_pkg::prod_t quotient,
    output logic            done
);
    import toom_pkg::*;

    prod_t                      remainder;
    prod_t                      divisor_top;
    logic                       lead;
    logic                       busy;
    logic [div_count_width-1:0] count;

    // divisor lined up under the top coefficient
    assign divisor_top = prod_t'(divisor) << (prod_width - 1 - divisor_degree);
    assign lead = remainder[prod_width-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            done  <= 1'b0;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            if (count == div_count_width'(prod_width - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // one quotient bit per step; the last divisor_degree cycles only pad the latency
    always_ff @(posedge clk) begin
        if (start) begin
            remainder <= dividend;
            quotient  <= '0;
        end else if (busy && count < div_count_width'(prod_width - divisor_degree)) begin
            remainder <= (remainder ^ (lead ? divisor_top : '0)) << 1;
            quotient  <= {quotient[prod_width-2:0], lead};
        end
    end

endmodule

/* rtl/toom4_mul.sv */
`timescale 1ns/1ps

module toom4_mul (
    input  logic              clk,
    input  logic              reset,
    input  toom_pkg::limb_t   U0,
    input  toom_pkg::limb_t   U1,
    input  toom_pkg::limb_t   U2,
    input  toom_pkg::limb_t   U3,
    input  toom_pkg::limb_t   V0,
    input  toom_pkg::limb_t   V1,
    input  toom_pkg::limb_t   V2,
    input  toom_pkg::limb_t   V3,
    output toom_pkg::result_t W,
    output logic              done
);
    import toom_pkg::*;

    op_t   mul_a0;
    op_t   mul_b0;
    op_t   mul_a1;
    op_t   mul_b1;
    prod_t mul_p0;
    prod_t mul_p1;
    logic  div_start0;
    logic  div_start1;
    logic  div_done0;
    logic  div_done1;
    prod_t dividend0;
    prod_t dividend1;
    prod_t quotient0;
    prod_t quotient1;

    toom_sequencer sequencer (
        .clk(clk), .reset(reset),
        .U0(U0), .U1(U1), .U2(U2), .U3(U3),
        .V0(V0), .V1(V1), .V2(V2), .V3(V3),
        .mul_a0(mul_a0), .mul_b0(mul_b0), .mul_a1(mul_a1), .mul_b1(mul_b1),
        .mul_p0(mul_p0), .mul_p1(mul_p1),
        .div_start0(div_start0), .div_start1(div_start1),
        .dividend0(dividend0), .dividend1(dividend1),
        .quotient0(quotient0), .quotient1(quotient1),
        .div_done0(div_done0), .div_done1(div_done1),
        .W(W), .done(done)
    );

    clmul_ks mult0 (.a(mul_a0), .b(mul_b0), .p(mul_p0));
    clmul_ks mult1 (.a(mul_a1), .b(mul_b1), .p(mul_p1));

    // x^4 + x
    exact_divider #(.divisor(5'b10010)) div_x4_x (
        .clk(clk), .reset(reset), .start(div_start0),
        .dividend(dividend0), .quotient(quotient0), .done(div_done0)
    );

    // x^4 + x^2
    exact_divider #(.divisor(5'b10100)) div_x4_x2 (
        .clk(clk), .reset(reset), .start(div_start1),
        .dividend(dividend1), .quotient(quotient1), .done(div_done1)
    );

endmodule

/* rtl/toom_pkg.sv */
package toom_pkg;

    // operand split into four limbs
    localparam int limb_width = 71;
    localparam int num_limbs = 4;

    // evaluated operands grow by up to degree 3, one spare bit
    localparam int op_width = 75;
    localparam int prod_width = 2 * op_width - 1;
    localparam int result_width = 2 * num_limbs * limb_width;

    // seven evaluation points, seven coefficients
    localparam int num_points = 7;

    // karatsuba split of a multiplier operand
    localparam int half_width = (op_width + 1) / 2;

    // exact divider
    localparam int divisor_degree = 4;
    localparam int div_count_width = $clog2(prod_width);

    typedef logic [limb_width-1:0] limb_t;
    typedef logic [op_width-1:0] op_t;
    typedef logic [prod_width-1:0] prod_t;
    typedef logic [result_width-1:0] result_t;

    typedef enum logic [4:0] {
        st_idle,
        st_eval_0, st_cap_0,
        st_eval_1, st_cap_1,
        st_eval_2, st_cap_2,
        st_eval_3, st_cap_3,
        st_interp_1, st_interp_2, st_interp_3, st_interp_4,
        st_interp_5, st_interp_6, st_interp_7,
        st_wait_div0_a, st_wait_div1_a,
        st_wait_div0_b, st_wait_div1_b,
        st_recombine,
        st_finished
    } seq_state_t;

endpackage

/* rtl/toom_sequencer.sv */
`timescale 1ns/1ps

module toom_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  toom_pkg::limb_t   U0,
    input  toom_pkg::limb_t   U1,
    input  toom_pkg::limb_t   U2,
    input  toom_pkg::limb_t   U3,
    input  toom_pkg::limb_t   V0,
    input  toom_pkg::limb_t   V1,
    input  toom_pkg::limb_t   V2,
    input  toom_pkg::limb_t   V3,
    output toom_pkg::op_t     mul_a0,
    output toom_pkg::op_t     mul_b0,
    output toom_pkg::op_t     mul_a1,
    output toom_pkg::op_t     mul_b1,
    input  toom_pkg::prod_t   mul_p0,
    input  toom_pkg::prod_t   mul_p1,
    output logic              div_start0,
    output logic              div_start1,
    output toom_pkg::prod_t   dividend0,
    output toom_pkg::prod_t   dividend1,
    input  toom_pkg::prod_t   quotient0,
    input  toom_pkg::prod_t   quotient1,
    input  logic              div_done0,
    input  logic              div_done1,
    output toom_pkg::result_t W,
    output logic              done
);
    import toom_pkg::*;

    seq_state_t state;

    // w_reg[i] ends up holding coefficient i of the product
    prod_t w_reg [num_points];
    result_t recombined;

    // multiply by the evaluation point x or x+1
    function automatic op_t times_point(input op_t t, input logic at_x1);
        return at_x1 ? (t ^ (t << 1)) : (t << 1);
    endfunction

    // horner sum, c3 is the leading coefficient
    function automatic op_t horner(
        input limb_t c0,
        input limb_t c1,
        input limb_t c2,
        input limb_t c3,
        input logic  at_x1
    );
        op_t acc;
        acc = op_t'(c3);
        acc = times_point(acc, at_x1) ^ op_t'(c2);
        acc = times_point(acc, at_x1) ^ op_t'(c1);
        acc = times_point(acc, at_x1) ^ op_t'(c0);
        return acc;
    endfunction

    // coefficients overlap at limb steps
    always_comb begin
        recombined = '0;
        for (int i = 0; i < num_points; i++) begin
            recombined = recombined ^ (result_t'(w_reg[i]) << (limb_width * i));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            div_start0 <= 1'b0;
            div_start1 <= 1'b0;
            W          <= '0;
            done       <= 1'b0;
        end else begin
            div_start0 <= 1'b0;
            div_start1 <= 1'b0;
            case (state)
                st_idle: begin
                    state <= st_eval_0;
                end
                // points 1 and x
                st_eval_0: begin
                    mul_a0 <= op_t'(U0 ^ U1 ^ U2 ^ U3);
                    mul_b0 <= op_t'(V0 ^ V1 ^ V2 ^ V3);
                    mul_a1 <= horner(U0, U1, U2, U3, 1'b0);
                    mul_b1 <= horner(V0, V1, V2, V3, 1'b0);
                    state  <= st_cap_0;
                end
                st_cap_0: begin
                    w_reg[3] <= mul_p0;
                    w_reg[4] <= mul_p1;
                    state    <= st_eval_1;
                end
                // x+1, and 1/x scaled by x^3
                st_eval_1: begin
                    mul_a0 <= horner(U0, U1, U2, U3, 1'b1);
                    mul_b0 <= horner(V0, V1, V2, V3, 1'b1);
                    mul_a1 <= horner(U3, U2, U1, U0, 1'b0);
                    mul_b1 <= horner(V3, V2, V1, V0, 1'b0);
                    state  <= st_cap_1;
                end
                st_cap_1: begin
                    w_reg[5] <= mul_p0;
                    w_reg[2] <= mul_p1;
                    state    <= st_eval_2;
                end
                // 1/(x+1) scaled by (x+1)^3, and 0
                st_eval_2: begin
                    mul_a0 <= horner(U3, U2, U1, U0, 1'b1);
                    mul_b0 <= horner(V3, V2, V1, V0, 1'b1);
                    mul_a1 <= op_t'(U0);
                    mul_b1 <= op_t'(V0);
                    state  <= st_cap_2;
                end
                st_cap_2: begin
                    w_reg[1] <= mul_p0;
                    w_reg[0] <= mul_p1;
                    state    <= st_eval_3;
                end
                // infinity, second multiplier idle
                st_eval_3: begin
                    mul_a0 <= op_t'(U3);
                    mul_b0 <= op_t'(V3);
                    state  <= st_cap_3;
                end
                st_cap_3: begin
                    w_reg[6] <= mul_p0;
                    state    <= st_interp_1;
                end
                // cancel c0 from the two inverse points
                st_interp_1: begin
                    w_reg[1] <= w_reg[1] ^ w_reg[2] ^ w_reg[0]
                              ^ (w_reg[0] << 2) ^ (w_reg[0] << 4);
                    state    <= st_interp_2;
                end
                // (c1+c5)(x^4+x)
                st_interp_2: begin
                    dividend0  <= w_reg[5] ^ w_reg[4] ^ w_reg[1] ^ w_reg[6]
                                ^ (w_reg[6] << 2) ^ (w_reg[6] << 4);
                    div_start0 <= 1'b1;
                    w_reg[2]   <= w_reg[2] ^ w_reg[6] ^ (w_reg[0] << 6);
                    state      <= st_wait_div0_a;
                end
                // start is still high in the first wait cycle, done may be stale
                st_wait_div0_a: begin
                    if (div_done0 && !div_start0) begin
                        w_reg[5] <= quotient0;
                        state    <= st_interp_3;
                    end
                end
                // (c2+c4)(x^4+x^2)
                st_interp_3: begin
                    dividend1  <= w_reg[4] ^ w_reg[2] ^ w_reg[0] ^ (w_reg[6] << 6)
                                ^ (w_reg[5] << 5) ^ (w_reg[5] << 1);
                    div_start1 <= 1'b1;
                    state      <= st_wait_div1_a;
                end
                st_wait_div1_a: begin
                    if (div_done1 && !div_start1) begin
                        w_reg[4] <= quotient1;
                        w_reg[3] <= w_reg[3] ^ w_reg[0] ^ w_reg[6];
                        state    <= st_interp_4;
                    end
                end
                st_interp_4: begin
                    w_reg[1] <= w_reg[1] ^ w_reg[3];
                    state    <= st_interp_5;
                end
                // w3 becomes c3 here
                st_interp_5: begin
                    w_reg[2] <= w_reg[2] ^ (w_reg[1] << 1) ^ (w_reg[3] << 2);
                    w_reg[3] <= w_reg[3] ^ w_reg[4] ^ w_reg[5];
                    state    <= st_interp_6;
                end
                st_interp_6: begin
                    dividend0  <= w_reg[1] ^ (w_reg[3] << 2) ^ (w_reg[3] << 1);
                    div_start0 <= 1'b1;
                    state      <= st_wait_div0_b;
                end
                // c1, then c5 from c1+c5
                st_wait_div0_b: begin
                    if (div_done0 && !div_start0) begin
                        w_reg[1] <= quotient0;
                        w_reg[5] <= w_reg[5] ^ quotient0;
                        state    <= st_interp_7;
                    end
                end
                st_interp_7: begin
                    dividend1  <= w_reg[2] ^ (w_reg[5] << 2) ^ (w_reg[5] << 1);
                    div_start1 <= 1'b1;
                    state      <= st_wait_div1_b;
                end
                // c2, then c4 from c2+c4
                st_wait_div1_b: begin
                    if (div_done1 && !div_start1) begin
                        w_reg[2] <= quotient1;
                        w_reg[4] <= w_reg[4] ^ quotient1;
                        state    <= st_recombine;
                    end
                end
                st_recombine: begin
                    W     <= recombined;
                    done  <= 1'b1;
                    state <= st_finished;
                end
                // hold result until the next reset
                st_finished: begin
                    state <= st_finished;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

/* tb.f */
rtl/toom_pkg.sv
rtl/clmul_ks.sv
rtl/exact_divider.sv
rtl/toom_sequencer.sv
rtl/toom4_mul.sv
verification/toom4_mul_assertions.sv
verification/tb_toom4_mul.sv

/* verification/tb_toom4_mul.sv */
`timescale 1ns/1ps

module tb_toom4_mul;
    import toom_pkg::*;

    localparam int operand_width = num_limbs * limb_width;
    localparam int num_random_runs = 4;
    localparam int num_runs = num_random_runs + 5;
    localparam int run_cycle_limit = 1200;
    localparam int clk_period_ns = 10;
    localparam int reset_cycles = 8;

    typedef logic [operand_width-1:0] operand_t;

    logic    clk;
    logic    reset;
    limb_t   U0;
    limb_t   U1;
    limb_t   U2;
    limb_t   U3;
    limb_t   V0;
    limb_t   V1;
    limb_t   V2;
    limb_t   V3;
    result_t W;
    logic    done;

    int compare_errors;
    int timeout_errors;
    int assertion_errors;

    toom4_mul dut0 (
        .clk(clk), .reset(reset),
        .U0(U0), .U1(U1), .U2(U2), .U3(U3),
        .V0(V0), .V1(V1), .V2(V2), .V3(V3),
        .W(W), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period_ns / 2) clk = ~clk;
    end

    // each run is bounded by its own cycle limit, plus reset and settle cycles
    initial begin
        #(num_runs * run_cycle_limit * clk_period_ns + 5000);
        $display("watchdog expired before all runs finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic limb_t random_limb();
        logic [95:0] bits;
        bits = {$urandom(), $urandom(), $urandom()};
        return bits[limb_width-1:0];
    endfunction

    // limb 0 holds the lowest coefficients
    function automatic operand_t random_operand();
        return {random_limb(), random_limb(), random_limb(), random_limb()};
    endfunction

    // plain shift-and-xor product over GF(2)
    function automatic result_t clmul_reference(input operand_t a, input operand_t b);
        result_t acc;
        acc = '0;
        for (int i = 0; i < operand_width; i++) begin
            if (b[i]) begin
                acc = acc ^ (result_t'(a) << i);
            end
        end
        return acc;
    endfunction

    task automatic run_case(
        input string    name,
        input operand_t u,
        input operand_t v,
        input result_t  expected
    );
        int cycles;
        @(posedge clk);
        #1;
        U0 = u[0*limb_width +: limb_width];
        U1 = u[1*limb_width +: limb_width];
        U2 = u[2*limb_width +: limb_width];
        U3 = u[3*limb_width +: limb_width];
        V0 = v[0*limb_width +: limb_width];
        V1 = v[1*limb_width +: limb_width];
        V2 = v[2*limb_width +: limb_width];
        V3 = v[3*limb_width +: limb_width];
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        cycles = 0;
        while (!done && cycles < run_cycle_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("%s: done did not rise within %0d cycles", name, run_cycle_limit);
            timeout_errors++;
        end else if (W !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, W);
            compare_errors++;
        end
        // a few cycles with done high for the hold checks
        repeat (4) @(posedge clk);
    endtask

    initial begin
        operand_t u;
        operand_t v;
        void'($urandom(32'h1772));
        compare_errors = 0;
        timeout_errors = 0;
        reset = 1'b1;
        U0 = '0;
        U1 = '0;
        U2 = '0;
        U3 = '0;
        V0 = '0;
        V1 = '0;
        V2 = '0;
        V3 = '0;

        for (int r = 0; r < num_random_runs; r++) begin
            u = random_operand();
            v = random_operand();
            run_case($sformatf("random_%0d", r), u, v, clmul_reference(u, v));
        end

        u = random_operand();
        run_case("zero_v", u, '0, '0);
        run_case("zero_u", '0, u, '0);
        run_case("unit_u", operand_t'(1), u, result_t'(u));
        run_case("unit_v", u, operand_t'(1), result_t'(u));
        run_case("all_ones", '1, '1, clmul_reference('1, '1));

        assertion_errors = dut0.chk_top.failures
                         + dut0.div_x4_x.chk_div.failures
                         + dut0.div_x4_x2.chk_div.failures;
        $display("errors: compare %0d, timeout %0d, assertion %0d",
                 compare_errors, timeout_errors, assertion_errors);
        if (compare_errors + timeout_errors + assertion_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verification/toom4_mul_assertions.sv */
`timescale 1ns/1ps

module toom4_mul_assertions #(
    parameter int width = 1,
    parameter bit check_exact = 1'b0
) (
    input logic             clk,
    input logic             reset,
    input logic             done,
    input logic [width-1:0] value
);
    int failures = 0;

    generate
        if (check_exact) begin : g_divider
            // remainder must be empty when the quotient is ready
            remainder_zero: assert property (
                @(posedge clk) disable iff (reset) $rose(done) |-> value == '0
            ) else begin
                failures++;
                $error("divider finished with a nonzero remainder");
            end
        end else begin : g_top
            done_low_after_reset: assert property (
                @(posedge clk) reset |=> !done
            ) else begin
                failures++;
                $error("done was high right after reset");
            end

            done_held: assert property (
                @(posedge clk) disable iff (reset) done |=> done
            ) else begin
                failures++;
                $error("done fell before reset");
            end

            result_held: assert property (
                @(posedge clk) disable iff (reset) $past(done) && done |-> $stable(value)
            ) else begin
                failures++;
                $error("W changed while done was high");
            end
        end
    endgenerate

endmodule

bind toom4_mul toom4_mul_assertions #(
    .width(toom_pkg::result_width), .check_exact(1'b0)
) chk_top (.clk(clk), .reset(reset), .done(done), .value(W));

bind exact_divider toom4_mul_assertions #(
    .width(toom_pkg::prod_width), .check_exact(1'b1)
) chk_div (.clk(clk), .reset(reset), .done(done), .value(remainder));
